// File: verilog/icache_pkg.sv
package icache_pkg;

    //////////////////////////////////////////////////
    // Cache geometry
    //////////////////////////////////////////////////

    localparam int addr_width   = 32;
    localparam int offset_width = 4;
    localparam int index_width  = 4;
    localparam int tag_width    = 24;
    localparam int way_count    = 2;
    localparam int line_width   = 128;
    localparam int word_width   = 32;

    //////////////////////////////////////////////////
    // Fetch and memory side transfers
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic                  valid;
        logic [word_width-1:0] instr;
    } fetch_rsp_t;

    // Line-aligned refill request
    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] addr;
    } mem_req_t;

    // Word 0 sits in the low bits
    typedef struct packed {
        logic                  valid;
        logic [line_width-1:0] line;
    } mem_rsp_t;

    //////////////////////////////////////////////////
    // Maintenance and control
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        cacop_init_index = 2'd0,
        cacop_inv_index  = 2'd1,
        cacop_inv_all    = 2'd2
    } cacop_e;

    typedef struct packed {
        logic                   valid;
        cacop_e                 op;
        logic [index_width-1:0] index;
        logic                   way;
    } cacop_req_t;

    // Write side of the tag/valid array
    typedef struct packed {
        logic [way_count-1:0]   we;
        logic [way_count-1:0]   inv;
        logic                   init;
        logic                   init_way;
        logic                   all_clr;
        logic [index_width-1:0] index;
        logic [tag_width-1:0]   tag;
    } tagv_wr_t;

    typedef enum logic [1:0] {
        lookup    = 2'd0,
        miss_wait = 2'd1,
        respond   = 2'd2
    } ctrl_state_e;

endpackage

// File: verilog/sdp_ram.sv
module sdp_ram #(
    parameter int width      = 32,
    parameter int depth_log2 = 4
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [depth_log2-1:0] waddr,
    input  logic [width-1:0]      din,
    input  logic [depth_log2-1:0] raddr,
    output logic [width-1:0]      dout
);

    logic [width-1:0] mem [2**depth_log2];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // Registered read, old data on a colliding write
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

// File: verilog/icache_tagv.sv
module icache_tagv (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [icache_pkg::index_width-1:0]    rd_index,
    input  logic [icache_pkg::tag_width-1:0]      cmp_tag,
    input  icache_pkg::tagv_wr_t                  wr,
    output logic [icache_pkg::way_count-1:0]      hit,
    output logic [icache_pkg::way_count-1:0]      valid
);

    for (genvar w = 0; w < icache_pkg::way_count; w++) begin : g_way

        logic [2**icache_pkg::index_width-1:0] valid_vec;
        logic                                  valid_upd;
        logic                                  valid_q;
        logic                                  init_here;
        logic [icache_pkg::tag_width-1:0]      tag_din;
        logic [icache_pkg::tag_width-1:0]      tag_rd;

        assign init_here = wr.init && (wr.init_way == 1'(w));

        //////////////////////////////////////////////////
        // Valid bit at the write index after this edge
        //////////////////////////////////////////////////

        always_comb begin
            valid_upd = valid_vec[wr.index];
            if (wr.all_clr) begin
                valid_upd = 1'b0;
            end else if (wr.init) begin
                // Init only touches its own way
                if (init_here) begin
                    valid_upd = 1'b0;
                end
            end else if (wr.inv[w]) begin
                valid_upd = 1'b0;
            end else if (wr.we[w]) begin
                valid_upd = 1'b1;
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_vec <= '0;
            end else if (wr.all_clr) begin
                valid_vec <= '0;
            end else begin
                valid_vec[wr.index] <= valid_upd;
            end
        end

        // Registered valid read with same-index forwarding
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_q <= 1'b0;
            end else if (wr.all_clr) begin
                valid_q <= 1'b0;
            end else if (wr.index == rd_index) begin
                valid_q <= valid_upd;
            end else begin
                valid_q <= valid_vec[rd_index];
            end
        end

        //////////////////////////////////////////////////
        // Tag storage
        //////////////////////////////////////////////////

        // Init writes a zero tag
        assign tag_din = init_here ? '0 : wr.tag;

        sdp_ram #(
            .width      (icache_pkg::tag_width),
            .depth_log2 (icache_pkg::index_width)
        ) tag_ram_inst (
            .clk   (clk),
            .we    (wr.we[w] || init_here),
            .waddr (wr.index),
            .din   (tag_din),
            .raddr (rd_index),
            .dout  (tag_rd)
        );

        assign valid[w] = valid_q;
        assign hit[w]   = (tag_rd == cmp_tag) && valid_q;

    end

endmodule

// File: verilog/icache_ctrl.sv
module icache_ctrl (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  icache_pkg::fetch_req_t               fetch_req,
    input  icache_pkg::cacop_req_t               cacop,
    input  icache_pkg::mem_rsp_t                 mem_rsp,
    input  logic [icache_pkg::way_count-1:0]     hit,
    input  logic [icache_pkg::way_count-1:0]     valid,
    input  logic [icache_pkg::line_width-1:0]    line0,
    input  logic [icache_pkg::line_width-1:0]    line1,
    output icache_pkg::fetch_rsp_t               fetch_rsp,
    output icache_pkg::mem_req_t                 mem_req,
    output logic                                 busy,
    output logic [icache_pkg::index_width-1:0]   rd_index,
    output logic [icache_pkg::tag_width-1:0]     cmp_tag,
    output icache_pkg::tagv_wr_t                 tagv_wr,
    output logic [icache_pkg::way_count-1:0]     data_we,
    output logic [icache_pkg::index_width-1:0]   data_windex,
    output logic [icache_pkg::line_width-1:0]    data_line
);

    icache_pkg::ctrl_state_e                  state;
    logic                                     s1_valid;
    logic [icache_pkg::addr_width-1:0]        s1_addr;
    logic [icache_pkg::index_width-1:0]       s1_index;
    logic [icache_pkg::tag_width-1:0]         s1_tag;
    logic [icache_pkg::offset_width-3:0]      s1_word;
    logic [2**icache_pkg::index_width-1:0]    mru;
    logic                                     victim_q;
    logic                                     victim_way;
    logic [icache_pkg::line_width-1:0]        fill_line;
    logic [icache_pkg::line_width-1:0]        hit_line;
    logic                                     lookup_hit;
    logic                                     lookup_miss;
    logic                                     accept;
    logic                                     cacop_go;
    logic                                     fill;

    function automatic logic [icache_pkg::word_width-1:0] pick_word(
        input logic [icache_pkg::line_width-1:0]   line,
        input logic [icache_pkg::offset_width-3:0] sel
    );
        return line[sel*icache_pkg::word_width +: icache_pkg::word_width];
    endfunction

    assign s1_index = s1_addr[icache_pkg::offset_width +: icache_pkg::index_width];
    assign s1_tag   = s1_addr[icache_pkg::addr_width-1 -: icache_pkg::tag_width];
    assign s1_word  = s1_addr[icache_pkg::offset_width-1:2];

    //////////////////////////////////////////////////
    // Pipeline control
    //////////////////////////////////////////////////

    assign lookup_hit  = (state == icache_pkg::lookup) && s1_valid && (|hit);
    assign lookup_miss = (state == icache_pkg::lookup) && s1_valid && !(|hit);
    assign fill        = (state == icache_pkg::miss_wait) && mem_rsp.valid;

    // Busy drops in the respond cycle
    assign busy     = lookup_miss || (state == icache_pkg::miss_wait);
    assign accept   = fetch_req.valid && !busy;
    assign cacop_go = cacop.valid && !busy && !fetch_req.valid;

    assign rd_index = fetch_req.addr[icache_pkg::offset_width +: icache_pkg::index_width];
    assign cmp_tag  = s1_tag;

    // First invalid way, else the least recent one
    always_comb begin
        if (!valid[0]) begin
            victim_way = 1'b0;
        end else if (!valid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = !mru[s1_index];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= icache_pkg::lookup;
            s1_valid <= 1'b0;
            victim_q <= 1'b0;
            mru      <= '0;
        end else begin
            s1_valid <= accept;
            if (lookup_hit) begin
                mru[s1_index] <= hit[1];
            end
            case (state)
                icache_pkg::lookup: begin
                    if (lookup_miss) begin
                        victim_q <= victim_way;
                        state    <= icache_pkg::miss_wait;
                    end
                end
                icache_pkg::miss_wait: begin
                    if (mem_rsp.valid) begin
                        mru[s1_index] <= victim_q;
                        state         <= icache_pkg::respond;
                    end
                end
                icache_pkg::respond: begin
                    state <= icache_pkg::lookup;
                end
                default: begin
                    state <= icache_pkg::lookup;
                end
            endcase
        end
    end

    // Request address and refill line
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_addr <= fetch_req.addr;
        end
        if (fill) begin
            fill_line <= mem_rsp.line;
        end
    end

    //////////////////////////////////////////////////
    // Responses and refill request
    //////////////////////////////////////////////////

    assign hit_line = hit[1] ? line1 : line0;

    always_comb begin
        fetch_rsp.valid = lookup_hit || (state == icache_pkg::respond);
        if (state == icache_pkg::respond) begin
            fetch_rsp.instr = pick_word(fill_line, s1_word);
        end else begin
            fetch_rsp.instr = pick_word(hit_line, s1_word);
        end
    end

    assign mem_req.valid = lookup_miss;
    assign mem_req.addr  = {s1_addr[icache_pkg::addr_width-1:icache_pkg::offset_width],
                            {icache_pkg::offset_width{1'b0}}};

    // Data RAM write on refill
    assign data_we     = fill ? (victim_q ? 2'b10 : 2'b01) : 2'b00;
    assign data_windex = s1_index;
    assign data_line   = mem_rsp.line;

    //////////////////////////////////////////////////
    // Tag/valid writes and maintenance ops
    //////////////////////////////////////////////////

    always_comb begin
        tagv_wr          = '0;
        tagv_wr.index    = s1_index;
        tagv_wr.tag      = s1_tag;
        if (fill) begin
            tagv_wr.we[victim_q] = 1'b1;
        end
        if (cacop_go) begin
            tagv_wr.index = cacop.index;
            case (cacop.op)
                icache_pkg::cacop_init_index: begin
                    tagv_wr.init     = 1'b1;
                    tagv_wr.init_way = cacop.way;
                end
                icache_pkg::cacop_inv_index: begin
                    tagv_wr.inv[cacop.way] = 1'b1;
                end
                icache_pkg::cacop_inv_all: begin
                    tagv_wr.all_clr = 1'b1;
                end
                default: begin
                    tagv_wr.all_clr = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: verilog/icache_top.sv
module icache_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  icache_pkg::fetch_req_t fetch_req,
    output icache_pkg::fetch_rsp_t fetch_rsp,
    output logic                   busy,
    output icache_pkg::mem_req_t   mem_req,
    input  icache_pkg::mem_rsp_t   mem_rsp,
    input  icache_pkg::cacop_req_t cacop
);

    logic [icache_pkg::index_width-1:0] rd_index;
    logic [icache_pkg::tag_width-1:0]   cmp_tag;
    icache_pkg::tagv_wr_t               tagv_wr;
    logic [icache_pkg::way_count-1:0]   hit;
    logic [icache_pkg::way_count-1:0]   valid;
    logic [icache_pkg::way_count-1:0]   data_we;
    logic [icache_pkg::index_width-1:0] data_windex;
    logic [icache_pkg::line_width-1:0]  data_line;
    logic [icache_pkg::line_width-1:0]  line0;
    logic [icache_pkg::line_width-1:0]  line1;

    //////////////////////////////////////////////////
    // Controller
    //////////////////////////////////////////////////

    icache_ctrl icache_ctrl_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_req   (fetch_req),
        .cacop       (cacop),
        .mem_rsp     (mem_rsp),
        .hit         (hit),
        .valid       (valid),
        .line0       (line0),
        .line1       (line1),
        .fetch_rsp   (fetch_rsp),
        .mem_req     (mem_req),
        .busy        (busy),
        .rd_index    (rd_index),
        .cmp_tag     (cmp_tag),
        .tagv_wr     (tagv_wr),
        .data_we     (data_we),
        .data_windex (data_windex),
        .data_line   (data_line)
    );

    //////////////////////////////////////////////////
    // Tag/valid array and line data
    //////////////////////////////////////////////////

    icache_tagv icache_tagv_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_index (rd_index),
        .cmp_tag  (cmp_tag),
        .wr       (tagv_wr),
        .hit      (hit),
        .valid    (valid)
    );

    // Way 0 lines
    sdp_ram #(
        .width      (icache_pkg::line_width),
        .depth_log2 (icache_pkg::index_width)
    ) data0_ram_inst (
        .clk   (clk),
        .we    (data_we[0]),
        .waddr (data_windex),
        .din   (data_line),
        .raddr (rd_index),
        .dout  (line0)
    );

    // Way 1 lines
    sdp_ram #(
        .width      (icache_pkg::line_width),
        .depth_log2 (icache_pkg::index_width)
    ) data1_ram_inst (
        .clk   (clk),
        .we    (data_we[1]),
        .waddr (data_windex),
        .din   (data_line),
        .raddr (rd_index),
        .dout  (line1)
    );

endmodule

// File: dv/icache_checker.sv
module icache_checker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  icache_pkg::fetch_req_t fetch_req,
    input  logic                   busy,
    input  icache_pkg::fetch_rsp_t fetch_rsp,
    input  icache_pkg::mem_req_t   mem_req,
    input  icache_pkg::mem_rsp_t   mem_rsp,
    input  logic                   exp_miss,
    input  logic [31:0]            exp_word,
    output int                     check_count,
    output int                     error_count
);

    // One accepted fetch and what the reference model predicted for it
    typedef struct packed {
        logic        miss;
        logic        requested;
        logic [31:0] addr;
        logic [31:0] word;
        int          cycle;
    } entry_t;

    entry_t pending[$];
    int     edge_count;
    int     fill_edge;

    always @(posedge clk) begin
        entry_t head;
        if (!arst_n) begin
            pending.delete();
            edge_count  = 0;
            fill_edge   = 0;
            check_count = 0;
            error_count = 0;
        end else begin
            edge_count++;

            //////////////////////////////////////////////////
            // Refill requests
            //////////////////////////////////////////////////

            if (mem_req.valid) begin
                if (pending.size() == 0 || !pending[0].miss || pending[0].requested) begin
                    error_count++;
                    $display("Error at %0t: mem_req to 0x%08h without a predicted miss",
                             $time, mem_req.addr);
                end else begin
                    head = pending[0];
                    if (mem_req.addr != {head.addr[31:4], 4'h0} ||
                        edge_count != head.cycle + 1) begin
                        error_count++;
                        $display("Error at %0t: mem_req 0x%08h for fetch 0x%08h is wrong",
                                 $time, mem_req.addr, head.addr);
                    end
                    head.requested = 1'b1;
                    pending[0]     = head;
                end
            end

            // Edge on which the refill line is written
            if (mem_rsp.valid) begin
                fill_edge = edge_count;
            end

            // Busy holds from mem_req until the refill answers
            if (pending.size() != 0 && pending[0].requested && !fetch_rsp.valid && !busy) begin
                error_count++;
                $display("Error at %0t: busy low while the refill of 0x%08h is outstanding",
                         $time, pending[0].addr);
            end

            //////////////////////////////////////////////////
            // Fetch responses
            //////////////////////////////////////////////////

            if (fetch_rsp.valid) begin
                if (pending.size() == 0) begin
                    error_count++;
                    $display("Error at %0t: fetch_rsp with no fetch outstanding", $time);
                end else begin
                    head = pending.pop_front();
                    check_count++;
                    if (fetch_rsp.instr != head.word) begin
                        error_count++;
                        $display("Error at %0t: fetch 0x%08h returned 0x%08h, expected 0x%08h",
                                 $time, head.addr, fetch_rsp.instr, head.word);
                    end
                    // A refill answers the cycle after its line, with busy already low
                    if (head.miss &&
                        (!head.requested || busy || edge_count != fill_edge + 1)) begin
                        error_count++;
                        $display("Error at %0t: refill of 0x%08h answered out of order or late",
                                 $time, head.addr);
                    end
                    if (!head.miss && edge_count != head.cycle + 1) begin
                        error_count++;
                        $display("Error at %0t: hit on 0x%08h answered after %0d cycles",
                                 $time, head.addr, edge_count - head.cycle);
                    end
                end
            end

            if (fetch_req.valid && !busy) begin
                pending.push_back({exp_miss, 1'b0, fetch_req.addr, exp_word, edge_count});
            end
        end
    end

endmodule

// File: dv/icache_tb.sv
module icache_tb;

    typedef logic [31:0] addr_q_t[$];

    logic                   clk = 1'b0;
    logic                   arst_n;
    icache_pkg::fetch_req_t fetch_req;
    icache_pkg::fetch_rsp_t fetch_rsp;
    logic                   busy;
    icache_pkg::mem_req_t   mem_req;
    icache_pkg::mem_rsp_t   mem_rsp = '0;
    icache_pkg::cacop_req_t cacop;
    logic                   exp_miss;
    logic [31:0]            exp_word;
    int                     check_count;
    int                     error_count;
    int                     timeouts = 0;
    int                     seed = 97851;
    int                     mem_wait = 0;
    logic [31:0]            mem_addr = '0;

    // Reference model state
    logic [23:0] model_tag [2][16];
    logic        model_valid [2][16];
    logic        model_mru [16];

    always #10 clk = ~clk;

    icache_top icache_top_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .busy      (busy),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .cacop     (cacop)
    );

    icache_checker icache_checker_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_req   (fetch_req),
        .busy        (busy),
        .fetch_rsp   (fetch_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .exp_miss    (exp_miss),
        .exp_word    (exp_word),
        .check_count (check_count),
        .error_count (error_count)
    );

    //////////////////////////////////////////////////
    // Memory contents and model
    //////////////////////////////////////////////////

    // Each word is its own address, scrambled
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    function automatic logic [127:0] line_at(input logic [31:0] addr);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = word_at({addr[31:4], 4'h0} + w * 4);
        end
        return line;
    endfunction

    // One refill per mem_req, 1 to 8 cycles later
    always @(negedge clk) begin
        mem_rsp.valid = 1'b0;
        if (mem_wait > 0) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                mem_rsp.valid = 1'b1;
                mem_rsp.line  = line_at(mem_addr);
            end
        end
        if (mem_req.valid) begin
            mem_addr = mem_req.addr;
            mem_wait = 1 + ($unsigned($random(seed)) % 8);
        end
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic void predict(input logic [31:0] addr, output logic miss,
                                    output logic [31:0] word);
        logic [3:0]  idx;
        logic [23:0] tag;
        logic        way;
        idx  = addr[7:4];
        tag  = addr[31:8];
        miss = 1'b1;
        way  = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == tag) begin
                miss = 1'b0;
                way  = 1'(w);
            end
        end
        if (miss) begin
            // First free way, else the older one
            if (!model_valid[0][idx]) begin
                way = 1'b0;
            end else if (!model_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = !model_mru[idx];
            end
            model_tag[way][idx]   = tag;
            model_valid[way][idx] = 1'b1;
        end
        model_mru[idx] = way;
        word = word_at(addr);
    endfunction

    function automatic void apply_maint(input icache_pkg::cacop_e op, input logic [3:0] idx,
                                        input logic way);
        if (op == icache_pkg::cacop_inv_all) begin
            foreach (model_valid[w, i]) begin
                model_valid[w][i] = 1'b0;
            end
        end else begin
            model_valid[way][idx] = 1'b0;
        end
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Issues the addresses as fast as busy allows, then waits for all answers
    task automatic fetch_burst(input addr_q_t addrs);
        int          sent;
        int          got;
        int          cycles;
        logic        miss;
        logic [31:0] word;
        sent   = 0;
        got    = 0;
        cycles = 0;
        while (got < addrs.size() && cycles < 16 * addrs.size() + 16) begin
            @(negedge clk);
            cycles++;
            if (fetch_rsp.valid) begin
                got++;
            end
            fetch_req.valid = 1'b0;
            cacop.valid     = 1'b0;
            if (sent < addrs.size() && !busy) begin
                predict(addrs[sent], miss, word);
                fetch_req.valid = 1'b1;
                fetch_req.addr  = addrs[sent];
                exp_miss        = miss;
                exp_word        = word;
                sent++;
            end
        end
        if (got < addrs.size()) begin
            timeouts++;
            $display("Timed out at %0t waiting for fetch responses, got %0d of %0d",
                     $time, got, addrs.size());
        end
        @(posedge clk);
    endtask

    task automatic fetch_one(input logic [31:0] addr);
        addr_q_t q;
        q.push_back(addr);
        fetch_burst(q);
    endtask

    task automatic maint(input icache_pkg::cacop_e op, input logic [3:0] idx, input logic way);
        @(negedge clk);
        fetch_req.valid = 1'b0;
        cacop.valid     = 1'b1;
        cacop.op        = op;
        cacop.index     = idx;
        cacop.way       = way;
        apply_maint(op, idx, way);
        @(posedge clk);
    endtask

    initial begin
        addr_q_t             q;
        logic [31:0]         r;
        int                  len;
        icache_pkg::cacop_e  op;
        arst_n    = 1'b0;
        fetch_req = '0;
        cacop     = '0;
        exp_miss  = 1'b0;
        exp_word  = '0;
        foreach (model_mru[i]) begin
            model_mru[i] = 1'b0;
        end
        apply_maint(icache_pkg::cacop_inv_all, 4'd0, 1'b0);
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Cold misses, then hits on the same lines
        fetch_one(32'h0000_1004);
        fetch_one(32'h0000_1008);
        fetch_one(32'h0000_100c);
        fetch_one(32'h0000_2014);
        fetch_one(32'h0000_2010);

        // Three tags on set 3
        fetch_one(32'h0001_0030);
        fetch_one(32'h0002_0034);
        fetch_one(32'h0001_0038);
        fetch_one(32'h0003_003c);
        fetch_one(32'h0002_0030);

        // Hits on consecutive cycles
        for (int i = 0; i < 8; i++) begin
            q.push_back(((i % 2) == 1 ? 32'h0000_2010 : 32'h0000_1000) + 4 * (i / 2));
        end
        q.push_back(32'h0003_0034);
        fetch_burst(q);

        // Per-way maintenance on set 5, fetch right behind it
        fetch_one(32'h0001_0050);
        fetch_one(32'h0002_0050);
        maint(icache_pkg::cacop_inv_index, 4'd5, 1'b0);
        fetch_one(32'h0002_0054);
        fetch_one(32'h0001_0058);
        maint(icache_pkg::cacop_init_index, 4'd5, 1'b1);
        fetch_one(32'h0002_005c);
        fetch_one(32'h0001_0050);

        // Barrier drops everything
        maint(icache_pkg::cacop_inv_all, 4'd0, 1'b0);
        fetch_one(32'h0000_1000);
        fetch_one(32'h0000_2010);
        fetch_one(32'h0002_0030);
        fetch_one(32'h0001_0050);

        // Random traffic over four sets and four tags
        for (int n = 0; n < 300; n++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                if (r[4:3] == 2'd3) begin
                    op = icache_pkg::cacop_inv_all;
                end else if (r[3]) begin
                    op = icache_pkg::cacop_inv_index;
                end else begin
                    op = icache_pkg::cacop_init_index;
                end
                maint(op, {2'b00, r[6:5]}, r[7]);
            end else begin
                q.delete();
                len = int'(r[4:3]) + 1;
                for (int i = 0; i < len; i++) begin
                    q.push_back($random(seed) & 32'h0000_033c);
                end
                fetch_burst(q);
            end
        end

        @(negedge clk);
        cacop.valid = 1'b0;
        @(negedge clk);
        $display("Fetch checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && check_count > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: filelist.f
verilog/icache_pkg.sv
verilog/sdp_ram.sv
verilog/icache_tagv.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
dv/icache_checker.sv
dv/icache_tb.sv

// File: Makefile
SRCS := $(shell cat filelist.f)

.PHONY: run clean

obj_dir/Vicache_tb: filelist.f $(SRCS)
	verilator --binary --timing --top-module icache_tb -f filelist.f

run: obj_dir/Vicache_tb
	@out="$$(./obj_dir/Vicache_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
